// File: exe_alu.sv
module exe_alu import exe_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  load,
  input  exe_op_e               in_op,
  input  logic [xlen-1:0]       in_rs,
  input  logic [xlen-1:0]       in_rt,
  input  logic [15:0]           in_imm,
  input  logic                  in_use_imm,
  input  logic                  in_zero_ext,
  input  logic [reg_addr_w-1:0] in_dest,
  input  logic [xlen-1:0]       hi,
  input  logic [xlen-1:0]       lo,
  output exe_op_e               op,
  output logic [xlen-1:0]       rs_value,
  output logic [xlen-1:0]       rt_value,
  output logic [xlen-1:0]       alu_result,
  output logic [xlen-1:0]       result,
  output logic [reg_addr_w-1:0] dest,
  output logic                  gr_we,
  output logic                  overflow
);

  logic [15:0]     imm_r;
  logic            use_imm_r;
  logic            zero_ext_r;
  logic            is_mem;
  logic [xlen-1:0] imm_ext;
  logic [xlen-1:0] src2;
  logic [xlen-1:0] sum;
  logic [xlen-1:0] diff;
  logic [4:0]      sa;

  always_ff @(posedge clk) begin
    if (reset) begin
      op <= op_sll;
    end else if (load) begin
      op <= in_op;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rs_value   <= in_rs;
      rt_value   <= in_rt;
      imm_r      <= in_imm;
      use_imm_r  <= in_use_imm;
      zero_ext_r <= in_zero_ext;
      dest       <= in_dest;
    end
  end

  assign is_mem = op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_sb, op_sh, op_sw};

  // address calculation always sign-extends the offset
  assign imm_ext = (zero_ext_r && !is_mem) ? {{(xlen-16){1'b0}}, imm_r}
                                           : {{(xlen-16){imm_r[15]}}, imm_r};
  assign src2 = (use_imm_r || is_mem) ? imm_ext : rt_value;
  assign sa   = imm_r[10:6];
  assign sum  = rs_value + src2;
  assign diff = rs_value - src2;

  always_comb begin
    case (op)
      op_add, op_addu, op_lb, op_lbu, op_lh, op_lhu, op_lw, op_sb, op_sh, op_sw:
        alu_result = sum;
      op_sub, op_subu: alu_result = diff;
      op_slt:  alu_result = {{(xlen-1){1'b0}}, $signed(rs_value) < $signed(src2)};
      op_sltu: alu_result = {{(xlen-1){1'b0}}, rs_value < src2};
      op_and:  alu_result = rs_value & src2;
      op_or:   alu_result = rs_value | src2;
      op_xor:  alu_result = rs_value ^ src2;
      op_nor:  alu_result = ~(rs_value | src2);
      op_sll:  alu_result = rt_value << sa;
      op_srl:  alu_result = rt_value >> sa;
      op_sra:  alu_result = $signed(rt_value) >>> sa;
      op_lui:  alu_result = {imm_r, {(xlen-16){1'b0}}};
      default: alu_result = '0;
    endcase
  end

  // signed overflow for the trapping forms only
  always_comb begin
    case (op)
      op_add:  overflow = (rs_value[xlen-1] == src2[xlen-1]) && (sum[xlen-1] != rs_value[xlen-1]);
      op_sub:  overflow = (rs_value[xlen-1] != src2[xlen-1]) && (diff[xlen-1] != rs_value[xlen-1]);
      default: overflow = 1'b0;
    endcase
  end

  always_comb begin
    case (op)
      op_mfhi: result = hi;
      op_mflo: result = lo;
      default: result = alu_result;
    endcase
  end

  always_comb begin
    case (op)
      op_div, op_divu, op_mthi, op_mtlo, op_sb, op_sh, op_sw: gr_we = 1'b0;
      default: gr_we = 1'b1;
    endcase
  end

endmodule

// File: exe_ctrl.sv
module exe_ctrl import exe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      in_valid,
  input  logic      out_ready,
  input  exe_op_e   op,
  input  logic      overflow,
  input  logic      misaligned,
  input  logic      data_addr_ok,
  input  logic      data_data_ok,
  input  logic      div_done,
  output logic      in_ready,
  output logic      out_valid,
  output logic      load,
  output logic      data_req,
  output logic      div_start,
  output logic      hi_we,
  output logic      lo_we,
  output logic      excp_valid,
  output exc_code_e excp_code
);

  exe_state_e state;
  exe_state_e next_state;
  logic       pending;
  logic       is_load;
  logic       is_store;
  logic       is_div;
  logic       enter_done;

  assign is_load  = op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
  assign is_store = op inside {op_sb, op_sh, op_sw};
  assign is_div   = op inside {op_div, op_divu};

  // Ov wins over the address errors
  always_comb begin
    if (overflow) begin
      excp_code = exc_ov;
    end else if (misaligned && is_load) begin
      excp_code = exc_adel;
    end else if (misaligned && is_store) begin
      excp_code = exc_ades;
    end else begin
      excp_code = exc_none;
    end
  end

  assign excp_valid = (excp_code != exc_none);

  assign in_ready  = (state == st_empty) || ((state == st_done) && out_ready);
  assign out_valid = (state == st_done);
  assign load      = in_valid && in_ready;

  // hold off while an older response is outstanding or the output is blocked
  assign data_req = (state == st_mem_req) && !pending && out_ready;

  always_comb begin
    next_state = state;
    case (state)
      st_empty: begin
        if (in_valid) begin
          next_state = st_exec;
        end
      end
      st_exec: begin
        if (excp_valid) begin
          next_state = st_done;
        end else if (is_load || is_store) begin
          next_state = st_mem_req;
        end else if (is_div) begin
          next_state = st_div;
        end else begin
          next_state = st_done;
        end
      end
      st_mem_req: begin
        if (data_req && data_addr_ok) begin
          next_state = is_load ? st_done : st_mem_wait;
        end
      end
      st_mem_wait: begin
        if (data_data_ok) begin
          next_state = st_done;
        end
      end
      st_div: begin
        if (div_done) begin
          next_state = st_done;
        end
      end
      st_done: begin
        if (out_ready) begin
          next_state = in_valid ? st_exec : st_empty;
        end
      end
      default: next_state = st_empty;
    endcase
  end

  assign enter_done = (next_state == st_done) && (state != st_done) && !excp_valid;
  assign hi_we      = enter_done && (is_div || (op == op_mthi));
  assign lo_we      = enter_done && (is_div || (op == op_mtlo));

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_empty;
      pending   <= 1'b0;
      div_start <= 1'b0;
    end else begin
      state     <= next_state;
      div_start <= (state == st_exec) && (next_state == st_div);
      if (data_req && data_addr_ok) begin
        pending <= 1'b1;
      end else if (data_data_ok) begin
        pending <= 1'b0;
      end
    end
  end

endmodule

// File: exe_div.sv
module exe_div import exe_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,
  input  logic            is_signed,
  input  logic [xlen-1:0] dividend,
  input  logic [xlen-1:0] divisor,
  output logic            done,
  output logic [xlen-1:0] quotient,
  output logic [xlen-1:0] remainder
);

  logic            busy;
  logic [5:0]      count;
  logic [xlen-1:0] quo_r;
  logic [xlen-1:0] rem_r;
  logic [xlen-1:0] div_r;
  logic            neg_q;
  logic            neg_r;
  logic [xlen-1:0] dividend_abs;
  logic [xlen-1:0] divisor_abs;
  logic [xlen:0]   shifted;
  logic [xlen+1:0] trial;

  assign dividend_abs = (is_signed && dividend[xlen-1]) ? -dividend : dividend;
  assign divisor_abs  = (is_signed && divisor[xlen-1]) ? -divisor : divisor;

  // bring down the next dividend bit, then try the subtract
  assign shifted = {rem_r, quo_r[xlen-1]};
  assign trial   = {1'b0, shifted} - {2'b00, div_r};

  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        count <= 6'(xlen);
      end else if (busy) begin
        count <= count - 6'd1;
        if (count == 6'd1) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      quo_r <= dividend_abs;
      rem_r <= '0;
      div_r <= divisor_abs;
      neg_q <= is_signed && (dividend[xlen-1] ^ divisor[xlen-1]);
      neg_r <= is_signed && dividend[xlen-1];
    end else if (busy) begin
      if (!trial[xlen+1]) begin
        rem_r <= trial[xlen-1:0];
        quo_r <= {quo_r[xlen-2:0], 1'b1};
      end else begin
        rem_r <= shifted[xlen-1:0];
        quo_r <= {quo_r[xlen-2:0], 1'b0};
      end
    end
  end

  // remainder follows the dividend sign
  assign quotient  = neg_q ? -quo_r : quo_r;
  assign remainder = neg_r ? -rem_r : rem_r;

endmodule

// File: exe_hilo.sv
module exe_hilo import exe_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            hi_we,
  input  logic            lo_we,
  input  exe_op_e         op,
  input  logic [xlen-1:0] rs_value,
  input  logic [xlen-1:0] quotient,
  input  logic [xlen-1:0] remainder,
  output logic [xlen-1:0] hi,
  output logic [xlen-1:0] lo
);

  logic is_div;

  assign is_div = op inside {op_div, op_divu};

  always_ff @(posedge clk) begin
    if (reset) begin
      hi <= '0;
      lo <= '0;
    end else begin
      if (hi_we) begin
        hi <= is_div ? remainder : rs_value;
      end
      if (lo_we) begin
        lo <= is_div ? quotient : rs_value;
      end
    end
  end

endmodule

// File: exe_mem_access.sv
module exe_mem_access import exe_pkg::*; (
  input  exe_op_e         op,
  input  logic [xlen-1:0] alu_result,
  input  logic [xlen-1:0] rt_value,
  output logic            misaligned,
  output logic            data_wr,
  output logic [1:0]      data_size,
  output logic [3:0]      data_wstrb,
  output logic [xlen-1:0] data_addr,
  output logic [xlen-1:0] data_wdata,
  output logic [xlen-1:0] badvaddr
);

  logic is_word;
  logic is_half;

  assign data_addr = alu_result;
  assign is_word   = op inside {op_lw, op_sw};
  assign is_half   = op inside {op_lh, op_lhu, op_sh};
  assign data_wr   = op inside {op_sb, op_sh, op_sw};

  assign misaligned = (is_word && (data_addr[1:0] != 2'b00)) || (is_half && data_addr[0]);
  assign badvaddr   = misaligned ? data_addr : '0;

  // 0 byte, 1 half, 2 word
  assign data_size = is_word ? 2'd2 : is_half ? 2'd1 : 2'd0;

  always_comb begin
    case (op)
      op_sb:   data_wstrb = 4'b0001 << data_addr[1:0];
      op_sh:   data_wstrb = data_addr[1] ? 4'b1100 : 4'b0011;
      op_sw:   data_wstrb = 4'b1111;
      default: data_wstrb = 4'b0000;
    endcase
  end

  // narrow stores replicated over every lane
  always_comb begin
    case (op)
      op_sb:   data_wdata = {4{rt_value[7:0]}};
      op_sh:   data_wdata = {2{rt_value[15:0]}};
      default: data_wdata = rt_value;
    endcase
  end

endmodule

// File: exe_pkg.sv
package exe_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // decoded operation handed over by the decode stage
  typedef enum logic [4:0] {
    op_add,
    op_addu,
    op_sub,
    op_subu,
    op_slt,
    op_sltu,
    op_and,
    op_or,
    op_xor,
    op_nor,
    op_sll,
    op_srl,
    op_sra,
    op_lui,
    op_div,
    op_divu,
    op_mfhi,
    op_mflo,
    op_mthi,
    op_mtlo,
    op_lb,
    op_lbu,
    op_lh,
    op_lhu,
    op_lw,
    op_sb,
    op_sh,
    op_sw
  } exe_op_e;

  // cp0 cause excode values
  typedef enum logic [4:0] {
    exc_none = 5'd0,
    exc_adel = 5'd4,
    exc_ades = 5'd5,
    exc_ov   = 5'd12
  } exc_code_e;

  typedef enum logic [2:0] {
    st_empty,
    st_exec,
    st_mem_req,
    st_mem_wait,
    st_div,
    st_done
  } exe_state_e;

endpackage

// File: exe_stage.sv
module exe_stage import exe_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  exe_op_e               in_op,
  input  logic [xlen-1:0]       in_rs,
  input  logic [xlen-1:0]       in_rt,
  input  logic [15:0]           in_imm,
  input  logic                  in_use_imm,
  input  logic                  in_zero_ext,
  input  logic [reg_addr_w-1:0] in_dest,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [xlen-1:0]       out_result,
  output logic [reg_addr_w-1:0] out_dest,
  output logic                  out_gr_we,
  output logic                  out_excp_valid,
  output exc_code_e             out_excp_code,
  output logic [xlen-1:0]       out_badvaddr,
  output logic                  data_req,
  output logic                  data_wr,
  output logic [1:0]            data_size,
  output logic [3:0]            data_wstrb,
  output logic [xlen-1:0]       data_addr,
  output logic [xlen-1:0]       data_wdata,
  input  logic                  data_addr_ok,
  input  logic                  data_data_ok
);

  exe_op_e         op;
  logic            load;
  logic            overflow;
  logic            misaligned;
  logic            div_start;
  logic            div_done;
  logic            hi_we;
  logic            lo_we;
  logic [xlen-1:0] rs_value;
  logic [xlen-1:0] rt_value;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] quotient;
  logic [xlen-1:0] remainder;
  logic [xlen-1:0] hi;
  logic [xlen-1:0] lo;

  exe_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .out_ready    (out_ready),
    .op           (op),
    .overflow     (overflow),
    .misaligned   (misaligned),
    .data_addr_ok (data_addr_ok),
    .data_data_ok (data_data_ok),
    .div_done     (div_done),
    .in_ready     (in_ready),
    .out_valid    (out_valid),
    .load         (load),
    .data_req     (data_req),
    .div_start    (div_start),
    .hi_we        (hi_we),
    .lo_we        (lo_we),
    .excp_valid   (out_excp_valid),
    .excp_code    (out_excp_code)
  );

  exe_alu u_alu (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .in_op       (in_op),
    .in_rs       (in_rs),
    .in_rt       (in_rt),
    .in_imm      (in_imm),
    .in_use_imm  (in_use_imm),
    .in_zero_ext (in_zero_ext),
    .in_dest     (in_dest),
    .hi          (hi),
    .lo          (lo),
    .op          (op),
    .rs_value    (rs_value),
    .rt_value    (rt_value),
    .alu_result  (alu_result),
    .result      (out_result),
    .dest        (out_dest),
    .gr_we       (out_gr_we),
    .overflow    (overflow)
  );

  // signed form only for div
  exe_div u_div (
    .clk       (clk),
    .reset     (reset),
    .start     (div_start),
    .is_signed (op == op_div),
    .dividend  (rs_value),
    .divisor   (rt_value),
    .done      (div_done),
    .quotient  (quotient),
    .remainder (remainder)
  );

  exe_mem_access u_mem_access (
    .op         (op),
    .alu_result (alu_result),
    .rt_value   (rt_value),
    .misaligned (misaligned),
    .data_wr    (data_wr),
    .data_size  (data_size),
    .data_wstrb (data_wstrb),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .badvaddr   (out_badvaddr)
  );

  exe_hilo u_hilo (
    .clk       (clk),
    .reset     (reset),
    .hi_we     (hi_we),
    .lo_we     (lo_we),
    .op        (op),
    .rs_value  (rs_value),
    .quotient  (quotient),
    .remainder (remainder),
    .hi        (hi),
    .lo        (lo)
  );

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_exe_stage -f sim.f -o tb_exe_stage_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_exe_stage_sim; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished"
exit 0

// File: sim.f
exe_pkg.sv
exe_alu.sv
exe_div.sv
exe_mem_access.sv
exe_hilo.sv
exe_ctrl.sv
exe_stage.sv
tb_exe_stage.sv

// File: tb_exe_stage.sv
module tb_exe_stage import exe_pkg::*; ();

  localparam int max_rows = 64;

  typedef struct packed {
    exe_op_e     op;
    logic [31:0] rs;
    logic [31:0] rt;
    logic [15:0] imm;
    logic        use_imm;
    logic        zero_ext;
    logic [4:0]  dest;
    logic        chk_result;
    logic [31:0] result;
    logic        gr_we;
    exc_code_e   code;
    logic [31:0] badvaddr;
    logic        mem_req;
    logic        wr;
    logic [1:0]  size;
    logic [3:0]  wstrb;
    logic [31:0] wdata;
  } row_t;

  logic        clk;
  logic        reset = 1'b1;
  logic        in_valid = 1'b0;
  logic        in_ready;
  exe_op_e     in_op = op_add;
  logic [31:0] in_rs = '0;
  logic [31:0] in_rt = '0;
  logic [15:0] in_imm = '0;
  logic        in_use_imm = 1'b0;
  logic        in_zero_ext = 1'b0;
  logic [4:0]  in_dest = '0;
  logic        out_valid;
  logic        out_ready = 1'b0;
  logic [31:0] out_result;
  logic [4:0]  out_dest;
  logic        out_gr_we;
  logic        out_excp_valid;
  exc_code_e   out_excp_code;
  logic [31:0] out_badvaddr;
  logic        data_req;
  logic        data_wr;
  logic [1:0]  data_size;
  logic [3:0]  data_wstrb;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic        data_addr_ok = 1'b1;
  logic        data_data_ok = 1'b0;

  row_t        rows [max_rows];
  int          taken_cnt [max_rows];
  int          nrows = 0;
  int          accepted [$];
  int          cur_idx = 0;
  int          out_count = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  int          outstanding = 0;
  int          addr_delay = 0;
  int          data_delay = 0;
  logic        held = 1'b0;
  logic [31:0] snap_result;
  logic [31:0] snap_badvaddr;
  logic [31:0] snap_flags;

  exe_stage exe_stage_i (
    .clk            (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .in_op          (in_op),
    .in_rs          (in_rs),
    .in_rt          (in_rt),
    .in_imm         (in_imm),
    .in_use_imm     (in_use_imm),
    .in_zero_ext    (in_zero_ext),
    .in_dest        (in_dest),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_result     (out_result),
    .out_dest       (out_dest),
    .out_gr_we      (out_gr_we),
    .out_excp_valid (out_excp_valid),
    .out_excp_code  (out_excp_code),
    .out_badvaddr   (out_badvaddr),
    .data_req       (data_req),
    .data_wr        (data_wr),
    .data_size      (data_size),
    .data_wstrb     (data_wstrb),
    .data_addr      (data_addr),
    .data_wdata     (data_wdata),
    .data_addr_ok   (data_addr_ok),
    .data_data_ok   (data_data_ok)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      stop_with_failure($sformatf("ERROR at time %0t: %s: got %h, expected %h",
                                  $time, what, actual, expected));
    end
  endtask

  task automatic add_row(input exe_op_e op, input logic [31:0] rs, input logic [31:0] rt,
                         input logic [15:0] imm, input logic use_imm, input logic zero_ext,
                         input logic [31:0] result);
    row_t r;
    r = '0;
    r.op = op;
    r.rs = rs;
    r.rt = rt;
    r.imm = imm;
    r.use_imm = use_imm;
    r.zero_ext = zero_ext;
    r.dest = 5'(nrows);
    r.chk_result = 1'b1;
    r.result = result;
    // alu, mf and load ops write the register file
    r.gr_we = op inside {op_add, op_addu, op_sub, op_subu, op_slt, op_sltu, op_and, op_or,
                         op_xor, op_nor, op_sll, op_srl, op_sra, op_lui, op_mfhi, op_mflo,
                         op_lb, op_lbu, op_lh, op_lhu, op_lw};
    r.code = exc_none;
    rows[nrows] = r;
    nrows++;
  endtask

  task automatic no_result();
    rows[nrows-1].chk_result = 1'b0;
  endtask

  task automatic expect_exc(input exc_code_e code, input logic [31:0] badvaddr);
    rows[nrows-1].code = code;
    rows[nrows-1].badvaddr = badvaddr;
  endtask

  task automatic expect_mem(input logic wr, input logic [1:0] size, input logic [3:0] wstrb,
                            input logic [31:0] wdata);
    rows[nrows-1].mem_req = 1'b1;
    rows[nrows-1].wr = wr;
    rows[nrows-1].size = size;
    rows[nrows-1].wstrb = wstrb;
    rows[nrows-1].wdata = wdata;
  endtask

  // divide, then read back remainder and quotient
  task automatic add_divide(input logic is_signed);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] q;
    logic [31:0] r;
    a = $urandom;
    b = $urandom >> $urandom_range(28, 4);
    if ($urandom_range(1, 0) == 1) begin
      b = -b;
    end
    if (b == 32'd0 || b == 32'hffff_ffff) begin
      b = 32'd7;
    end
    if (is_signed) begin
      q = 32'($signed(a) / $signed(b));
      r = 32'($signed(a) % $signed(b));
    end else begin
      q = a / b;
      r = a % b;
    end
    add_row(is_signed ? op_div : op_divu, a, b, 16'h0, 1'b0, 1'b0, 32'h0);
    no_result();
    add_row(op_mfhi, 32'h0, 32'h0, 16'h0, 1'b0, 1'b0, r);
    add_row(op_mflo, 32'h0, 32'h0, 16'h0, 1'b0, 1'b0, q);
  endtask

  task automatic build_table();
    add_row(op_addu, 32'h7fff_ffff, 32'h1, 16'h0, 1'b0, 1'b0, 32'h8000_0000);
    add_row(op_add, 32'h5, 32'h0, 16'hfffd, 1'b1, 1'b0, 32'h2);
    add_row(op_sub, 32'ha, 32'h3, 16'h0, 1'b0, 1'b0, 32'h7);
    add_row(op_subu, 32'h0, 32'h1, 16'h0, 1'b0, 1'b0, 32'hffff_ffff);
    add_row(op_slt, 32'hffff_fffe, 32'h1, 16'h0, 1'b0, 1'b0, 32'h1);
    add_row(op_sltu, 32'hffff_fffe, 32'h1, 16'h0, 1'b0, 1'b0, 32'h0);
    add_row(op_sltu, 32'h3, 32'h0, 16'hffff, 1'b1, 1'b0, 32'h1);
    add_row(op_and, 32'hf0f0_1234, 32'h0ff0_ff00, 16'h0, 1'b0, 1'b0, 32'h00f0_1200);
    add_row(op_and, 32'hffff_ffff, 32'h0, 16'h8421, 1'b1, 1'b1, 32'h0000_8421);
    add_row(op_or, 32'ha000_0000, 32'h5, 16'h0, 1'b0, 1'b0, 32'ha000_0005);
    add_row(op_or, 32'h1234_0000, 32'h0, 16'hbeef, 1'b1, 1'b1, 32'h1234_beef);
    add_row(op_xor, 32'hffff_0000, 32'h0f0f_0f0f, 16'h0, 1'b0, 1'b0, 32'hf0f0_0f0f);
    add_row(op_nor, 32'h0000_ff00, 32'h00ff_0000, 16'h0, 1'b0, 1'b0, 32'hff00_00ff);
    // shift amount sits in imm[10:6]
    add_row(op_sll, 32'h0, 32'h1, 16'h07c0, 1'b0, 1'b0, 32'h8000_0000);
    add_row(op_srl, 32'h0, 32'h8000_0000, 16'h0100, 1'b0, 1'b0, 32'h0800_0000);
    add_row(op_sra, 32'h0, 32'h8000_0000, 16'h0100, 1'b0, 1'b0, 32'hf800_0000);
    add_row(op_sra, 32'h0, 32'h7000_0000, 16'h0700, 1'b0, 1'b0, 32'h7);
    add_row(op_lui, 32'h0, 32'h0, 16'hdead, 1'b1, 1'b0, 32'hdead_0000);
    add_row(op_sub, 32'h8000_0000, 32'h1, 16'h0, 1'b0, 1'b0, 32'h0);
    no_result();
    expect_exc(exc_ov, 32'h0);
    add_row(op_add, 32'h8000_0000, 32'h0, 16'hffff, 1'b1, 1'b0, 32'h0);
    no_result();
    expect_exc(exc_ov, 32'h0);
    // hi/lo must survive an overflowing add
    add_row(op_mthi, 32'h1111_1111, 32'h0, 16'h0, 1'b0, 1'b0, 32'h0);
    no_result();
    add_row(op_mtlo, 32'h2222_2222, 32'h0, 16'h0, 1'b0, 1'b0, 32'h0);
    no_result();
    add_row(op_add, 32'h7fff_ffff, 32'h1, 16'h0, 1'b0, 1'b0, 32'h0);
    no_result();
    expect_exc(exc_ov, 32'h0);
    add_row(op_mfhi, 32'h0, 32'h0, 16'h0, 1'b0, 1'b0, 32'h1111_1111);
    add_row(op_mflo, 32'h0, 32'h0, 16'h0, 1'b0, 1'b0, 32'h2222_2222);
    for (int i = 0; i < 3; i++) begin
      add_divide(1'b1);
      add_divide(1'b0);
    end
    add_row(op_sw, 32'h1000, 32'hcafe_babe, 16'h0010, 1'b1, 1'b0, 32'h1010);
    expect_mem(1'b1, 2'd2, 4'b1111, 32'hcafe_babe);
    add_row(op_sh, 32'h2000, 32'h1234_5678, 16'h0002, 1'b1, 1'b0, 32'h2002);
    expect_mem(1'b1, 2'd1, 4'b1100, 32'h5678_5678);
    add_row(op_sh, 32'h2000, 32'hffff_9abc, 16'h0000, 1'b1, 1'b0, 32'h2000);
    expect_mem(1'b1, 2'd1, 4'b0011, 32'h9abc_9abc);
    add_row(op_sb, 32'h3000, 32'h0000_00a5, 16'hffff, 1'b1, 1'b0, 32'h2fff);
    expect_mem(1'b1, 2'd0, 4'b1000, 32'ha5a5_a5a5);
    add_row(op_sb, 32'h3000, 32'h1234_5601, 16'h0001, 1'b1, 1'b0, 32'h3001);
    expect_mem(1'b1, 2'd0, 4'b0010, 32'h0101_0101);
    add_row(op_lw, 32'h4000, 32'h0, 16'h0008, 1'b1, 1'b0, 32'h4008);
    expect_mem(1'b0, 2'd2, 4'b0000, 32'h0);
    add_row(op_lh, 32'h4000, 32'h0, 16'hfffe, 1'b1, 1'b0, 32'h3ffe);
    expect_mem(1'b0, 2'd1, 4'b0000, 32'h0);
    add_row(op_lhu, 32'h4000, 32'h0, 16'h0002, 1'b1, 1'b0, 32'h4002);
    expect_mem(1'b0, 2'd1, 4'b0000, 32'h0);
    add_row(op_lb, 32'h4000, 32'h0, 16'h0003, 1'b1, 1'b0, 32'h4003);
    expect_mem(1'b0, 2'd0, 4'b0000, 32'h0);
    add_row(op_lbu, 32'h4000, 32'h0, 16'h0001, 1'b1, 1'b0, 32'h4001);
    expect_mem(1'b0, 2'd0, 4'b0000, 32'h0);
    add_row(op_lw, 32'h4000, 32'h0, 16'h0002, 1'b1, 1'b0, 32'h4002);
    expect_exc(exc_adel, 32'h4002);
    add_row(op_lh, 32'h4000, 32'h0, 16'h0011, 1'b1, 1'b0, 32'h4011);
    expect_exc(exc_adel, 32'h4011);
    add_row(op_sw, 32'h5000, 32'h1, 16'h0001, 1'b1, 1'b0, 32'h5001);
    expect_exc(exc_ades, 32'h5001);
    add_row(op_sh, 32'h5000, 32'h1, 16'h0023, 1'b1, 1'b0, 32'h5023);
    expect_exc(exc_ades, 32'h5023);
  endtask

  function automatic logic [31:0] out_flags();
    return {20'h0, out_dest, out_gr_we, out_excp_valid, out_excp_code};
  endfunction

  task automatic check_output(input int idx);
    row_t r;
    logic exc;
    r = rows[idx];
    exc = (r.code != exc_none);
    if (r.chk_result) begin
      check(out_result, r.result, $sformatf("row %0d out_result", idx));
    end
    check(32'(out_dest), 32'(r.dest), $sformatf("row %0d out_dest", idx));
    check(32'(out_gr_we), 32'(r.gr_we), $sformatf("row %0d out_gr_we", idx));
    check(32'(out_excp_valid), 32'(exc), $sformatf("row %0d out_excp_valid", idx));
    check(32'(out_excp_code), 32'(r.code), $sformatf("row %0d out_excp_code", idx));
    check(out_badvaddr, r.badvaddr, $sformatf("row %0d out_badvaddr", idx));
    check(32'(taken_cnt[idx]), (r.mem_req && !exc) ? 32'd1 : 32'd0,
          $sformatf("row %0d taken memory requests", idx));
    if (r.wr) begin
      check(32'(outstanding), 32'd0, $sformatf("row %0d store done before data_ok", idx));
    end
  endtask

  task automatic check_request();
    row_t r;
    r = rows[cur_idx];
    check(32'(r.mem_req), 32'd1, "data_req for an instruction without a memory access");
    check(32'(outstanding), 32'd0, "data_req before the previous data_data_ok");
    check(32'(out_ready), 32'd1, "data_req while out_ready is low");
    check(data_addr, r.result, "data_addr");
    check(32'(data_wr), 32'(r.wr), "data_wr");
    check(32'(data_size), 32'(r.size), "data_size");
    check(32'(data_wstrb), 32'(r.wstrb), "data_wstrb");
    if (r.wr) begin
      check(data_wdata, r.wdata, "data_wdata");
    end
  endtask

  // random back-pressure on the output
  always @(posedge clk) begin
    if (!reset) begin
      out_ready <= ($urandom_range(3, 0) != 0);
    end
  end

  // memory responder with one response in flight
  always @(posedge clk) begin
    data_data_ok <= 1'b0;
    if (data_data_ok) begin
      outstanding = 0;
    end
    if (data_delay != 0) begin
      data_delay = data_delay - 1;
      if (data_delay == 0) begin
        data_data_ok <= 1'b1;
      end
    end
    if (data_req) begin
      check_request();
      if (data_addr_ok) begin
        taken_cnt[cur_idx]++;
        outstanding = 1;
        data_delay = $urandom_range(4, 1);
        addr_delay = $urandom_range(3, 0);
        data_addr_ok <= (addr_delay == 0);
      end else if (addr_delay != 0) begin
        addr_delay = addr_delay - 1;
        data_addr_ok <= (addr_delay == 0);
      end
    end
  end

  always @(posedge clk) begin
    int idx;
    if (!reset && out_valid) begin
      if (held) begin
        check(out_result, snap_result, "out_result changed while stalled");
        check(out_badvaddr, snap_badvaddr, "out_badvaddr changed while stalled");
        check(out_flags(), snap_flags, "output flags changed while stalled");
      end
      if (out_ready) begin
        check(32'(accepted.size() != 0), 32'd1, "output without an accepted instruction");
        idx = accepted.pop_front();
        check_output(idx);
        out_count++;
        held = 1'b0;
      end else begin
        held = 1'b1;
        snap_result = out_result;
        snap_badvaddr = out_badvaddr;
        snap_flags = out_flags();
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      stop_with_failure("timeout: outputs stopped arriving");
    end
  end

  initial begin
    void'($urandom(32'h8fd0));
    build_table();
    cycle_limit = nrows * 60 + 200;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < nrows; i++) begin
      in_valid    <= 1'b1;
      in_op       <= rows[i].op;
      in_rs       <= rows[i].rs;
      in_rt       <= rows[i].rt;
      in_imm      <= rows[i].imm;
      in_use_imm  <= rows[i].use_imm;
      in_zero_ext <= rows[i].zero_ext;
      in_dest     <= rows[i].dest;
      @(posedge clk);
      while (!in_ready) begin
        @(posedge clk);
      end
      cur_idx = i;
      accepted.push_back(i);
    end
    in_valid <= 1'b0;
    while (out_count < nrows) begin
      @(posedge clk);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
